//--- source/kin_macros.svh
// jacobian accelerator constants
// fixed-point format, joint count, bus widths and the frame store memory map
`ifndef KIN_MACROS_SVH
`define KIN_MACROS_SVH

`define FIX_W        27   // Q11.16 value width
`define FRAC_BITS    16
`define JOINTS       6
`define ADR_W        7    // word address
`define DAT_W        32
`define FRAME_WORDS  12   // 3x4 frame, row-major

// memory map, frame j at 12*j
`define Z_BASE       72
`define S_BASE       75
`define TYPE_ADR     78   // bit j set for a revolute joint
`define JAC_BASE     80   // column c row r at 80 + 6*c + r

// column_calc operand slots
`define OPNDS        18
`define OPND_T_BASE  9    // frame column 3
`define OPND_Z_BASE  12
`define OPND_S_BASE  15

`endif

//--- source/kin_pkg.sv
// jacobian accelerator types
// value, bus and index widths plus the state encodings of both FSMs
`include "kin_macros.svh"

package kin_pkg;

	typedef logic [`FIX_W-1:0] fix_t;      // Q11.16
	typedef logic [`ADR_W-1:0] adr_t;
	typedef logic [`DAT_W-1:0] dat_t;      // fix_t sign-extended
	typedef logic [4:0]        opnd_sel_t; // R 0-8, t 9-11, z 12-14, s 15-17
	typedef logic [2:0]        row_sel_t;

	typedef enum logic [1:0] {
		calc_idle,
		calc_axis,
		calc_cross,
		calc_finish
	} calc_state_t;

	typedef enum logic [2:0] {
		eng_idle,
		eng_fetch_type,
		eng_fetch_zs,
		eng_fetch_frame,
		eng_compute,
		eng_store_col,
		eng_finish
	} eng_state_t;

endpackage

//--- source/frame_store.sv
// frame store
// 128-word memory behind a Wishbone classic slave port
// one wait state per transfer, ack is registered and lasts one cycle
`include "kin_macros.svh"

module frame_store (
	input  logic          i,
	input  logic          rst_n,
	input  logic          cyc,
	input  logic          stb,
	input  logic          we,
	input  kin_pkg::adr_t adr,
	input  kin_pkg::dat_t wdata,
	output kin_pkg::dat_t rdata,
	output logic          ack
);

	kin_pkg::dat_t mem [1 << `ADR_W];
	logic req;

	// new request, not the tail of the one just acked
	assign req = cyc & stb & ~ack;

	always_ff @(posedge i or negedge rst_n) begin
		if (!rst_n) begin
			ack <= 1'b0;
		end else begin
			ack <= req;
		end
	end

	always_ff @(posedge i) begin
		if (req) begin
			if (we) begin
				mem[adr] <= wdata;
			end
			rdata <= mem[adr]; // valid together with ack
		end
	end

endmodule

//--- source/bus_arbiter.sv
// two-master Wishbone classic arbiter
// host has priority when the bus is free, the owner keeps the bus
// for as long as its cyc stays high
module bus_arbiter (
	input  logic          i,
	input  logic          rst_n,
	input  logic          host_cyc,
	input  logic          host_stb,
	input  logic          host_we,
	input  kin_pkg::adr_t host_adr,
	input  kin_pkg::dat_t host_wdata,
	output kin_pkg::dat_t host_rdata,
	output logic          host_ack,
	input  logic          eng_cyc,
	input  logic          eng_stb,
	input  logic          eng_we,
	input  kin_pkg::adr_t eng_adr,
	input  kin_pkg::dat_t eng_wdata,
	output kin_pkg::dat_t eng_rdata,
	output logic          eng_ack,
	output logic          mem_cyc,
	output logic          mem_stb,
	output logic          mem_we,
	output kin_pkg::adr_t mem_adr,
	output kin_pkg::dat_t mem_wdata,
	input  kin_pkg::dat_t mem_rdata,
	input  logic          mem_ack
);

	logic own_eng;   // registered owner, 1 = engine
	logic grant_eng;

	always_comb begin
		if (own_eng ? eng_cyc : host_cyc) begin
			grant_eng = own_eng; // owner still in its cycle
		end else begin
			grant_eng = ~host_cyc & eng_cyc;
		end
	end

	always_ff @(posedge i or negedge rst_n) begin
		if (!rst_n) begin
			own_eng <= 1'b0;
		end else begin
			own_eng <= grant_eng;
		end
	end

	assign mem_cyc   = grant_eng ? eng_cyc   : host_cyc;
	assign mem_stb   = grant_eng ? eng_stb   : host_stb;
	assign mem_we    = grant_eng ? eng_we    : host_we;
	assign mem_adr   = grant_eng ? eng_adr   : host_adr;
	assign mem_wdata = grant_eng ? eng_wdata : host_wdata;

	// the waiting master sees no ack
	assign host_ack   = mem_ack & ~grant_eng;
	assign eng_ack    = mem_ack & grant_eng;
	assign host_rdata = grant_eng ? '0 : mem_rdata;
	assign eng_rdata  = grant_eng ? mem_rdata : '0;

endmodule

//--- source/column_calc.sv
// jacobian column datapath
// operand registers and one shared multiplier, v = R*z then v x (s - t)
// ready pulses 16 cycles after go: 9 axis products, 6 cross terms, 1 finish
`include "kin_macros.svh"

module column_calc (
	input  logic               i,
	input  logic               rst_n,
	input  logic               load,
	input  kin_pkg::opnd_sel_t load_sel,
	input  kin_pkg::fix_t      load_data,
	input  logic               go,
	input  logic               revolute,
	input  kin_pkg::row_sel_t  res_sel,
	output kin_pkg::fix_t      res_data,
	output logic               ready
);

	kin_pkg::fix_t opnd [`OPNDS];
	kin_pkg::fix_t p [3];
	kin_pkg::fix_t v [3];
	kin_pkg::fix_t cx [3];  // cross product rows
	kin_pkg::fix_t res [6];
	kin_pkg::calc_state_t state;
	logic [3:0] step;
	logic [1:0] row_cnt;
	logic [1:0] col_cnt;
	logic rev_q;
	logic [1:0] cx_v;
	logic [1:0] cx_p;
	kin_pkg::fix_t mul_a;
	kin_pkg::fix_t mul_b;
	kin_pkg::fix_t mul_res;
	logic signed [2*`FIX_W-1:0] prod;

	always_ff @(posedge i) begin
		if (load) begin
			opnd[load_sel] <= load_data;
		end
	end

	// cross term order: v1p2 v2p1, v2p0 v0p2, v0p1 v1p0
	always_comb begin
		cx_v = 2'd0;
		cx_p = 2'd0;
		case (step)
			4'd0: begin cx_v = 2'd1; cx_p = 2'd2; end
			4'd1: begin cx_v = 2'd2; cx_p = 2'd1; end
			4'd2: begin cx_v = 2'd2; cx_p = 2'd0; end
			4'd3: begin cx_v = 2'd0; cx_p = 2'd2; end
			4'd4: begin cx_v = 2'd0; cx_p = 2'd1; end
			4'd5: begin cx_v = 2'd1; cx_p = 2'd0; end
			default: ;
		endcase
	end

	always_comb begin
		if (state == kin_pkg::calc_axis) begin
			mul_a = opnd[step];                     // R row-major
			mul_b = opnd[`OPND_Z_BASE + col_cnt];
		end else begin
			mul_a = v[cx_v];
			mul_b = p[cx_p];
		end
		prod    = $signed(mul_a) * $signed(mul_b);
		mul_res = prod[`FRAC_BITS +: `FIX_W]; // >>> 16, low 27 bits
	end

	always_ff @(posedge i or negedge rst_n) begin
		if (!rst_n) begin
			state   <= kin_pkg::calc_idle;
			step    <= 4'd0;
			row_cnt <= 2'd0;
			col_cnt <= 2'd0;
			ready   <= 1'b0;
		end else begin
			ready <= 1'b0;
			case (state)
				kin_pkg::calc_idle: begin
					if (go) begin
						state   <= kin_pkg::calc_axis;
						step    <= 4'd0;
						row_cnt <= 2'd0;
						col_cnt <= 2'd0;
					end
				end
				kin_pkg::calc_axis: begin
					if (step == 4'd8) begin
						state <= kin_pkg::calc_cross;
						step  <= 4'd0;
					end else begin
						step <= step + 4'd1;
					end
					if (col_cnt == 2'd2) begin
						col_cnt <= 2'd0;
						row_cnt <= row_cnt + 2'd1;
					end else begin
						col_cnt <= col_cnt + 2'd1;
					end
				end
				kin_pkg::calc_cross: begin
					if (step == 4'd5) begin
						state <= kin_pkg::calc_finish;
						step  <= 4'd0;
					end else begin
						step <= step + 4'd1;
					end
				end
				default: begin
					state <= kin_pkg::calc_idle;
					ready <= 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge i) begin
		case (state)
			kin_pkg::calc_idle: begin
				if (go) begin
					rev_q <= revolute;
					for (int k = 0; k < 3; k++) begin
						p[k] <= opnd[`OPND_S_BASE + k] - opnd[`OPND_T_BASE + k];
					end
				end
			end
			kin_pkg::calc_axis: begin
				if (col_cnt == 2'd0) begin
					v[row_cnt] <= mul_res;
				end else begin
					v[row_cnt] <= v[row_cnt] + mul_res;
				end
			end
			kin_pkg::calc_cross: begin
				if (!step[0]) begin
					cx[step[2:1]] <= mul_res;
				end else begin
					cx[step[2:1]] <= cx[step[2:1]] - mul_res;
				end
			end
			default: begin
				// prismatic: v on top, zero below
				for (int k = 0; k < 3; k++) begin
					res[k]     <= rev_q ? cx[k] : v[k];
					res[k + 3] <= rev_q ? v[k] : '0;
				end
			end
		endcase
	end

	assign res_data = res[res_sel];

endmodule

//--- source/jacobian_engine.sv
// jacobian engine
// Wishbone master that fetches the joint types, z, s and each frame,
// runs column_calc per joint and writes the six result words back
`include "kin_macros.svh"

module jacobian_engine (
	input  logic          i,
	input  logic          rst_n,
	input  logic          start,
	input  logic          ack,
	input  kin_pkg::dat_t rdata,
	output logic          cyc,
	output logic          stb,
	output logic          we,
	output kin_pkg::adr_t adr,
	output kin_pkg::dat_t wdata,
	output logic          busy,
	output logic          done
);

	kin_pkg::eng_state_t state;
	logic [2:0] joint;
	logic [3:0] widx;           // word within the current block
	logic [`JOINTS-1:0] type_word;
	logic xfer;
	logic need_bus;
	logic load;
	kin_pkg::opnd_sel_t load_sel;
	kin_pkg::fix_t load_data;
	logic go;
	logic revolute;
	logic ready;
	kin_pkg::row_sel_t res_sel;
	kin_pkg::fix_t res_data;

	// frame word row-major 3x4 to operand slot
	function automatic kin_pkg::opnd_sel_t frame_sel(input logic [3:0] w);
		logic [1:0] r;
		logic [1:0] c;
		r = w[3:2];
		c = w[1:0];
		if (c == 2'd3) begin
			return kin_pkg::opnd_sel_t'(`OPND_T_BASE + r);
		end
		return kin_pkg::opnd_sel_t'(3 * r + c);
	endfunction

	assign xfer     = cyc & ack;
	assign need_bus = (state == kin_pkg::eng_fetch_type) || (state == kin_pkg::eng_fetch_zs) ||
		(state == kin_pkg::eng_fetch_frame) || (state == kin_pkg::eng_store_col);
	assign stb      = cyc;
	assign we       = (state == kin_pkg::eng_store_col);
	assign res_sel  = kin_pkg::row_sel_t'(widx);
	assign wdata    = {{(`DAT_W - `FIX_W){res_data[`FIX_W-1]}}, res_data};
	assign revolute = type_word[joint];

	always_comb begin
		case (state)
			kin_pkg::eng_fetch_type:  adr = kin_pkg::adr_t'(`TYPE_ADR);
			kin_pkg::eng_fetch_zs:    adr = kin_pkg::adr_t'(`Z_BASE + widx); // z then s
			kin_pkg::eng_fetch_frame: adr = kin_pkg::adr_t'(`FRAME_WORDS * joint + widx);
			kin_pkg::eng_store_col:   adr = kin_pkg::adr_t'(`JAC_BASE + `JOINTS * joint + widx);
			default:                  adr = '0;
		endcase
	end

	// operands written straight from the bus on ack
	always_comb begin
		load      = xfer & ((state == kin_pkg::eng_fetch_zs) || (state == kin_pkg::eng_fetch_frame));
		load_data = rdata[`FIX_W-1:0];
		if (state == kin_pkg::eng_fetch_zs) begin
			load_sel = kin_pkg::opnd_sel_t'(`OPND_Z_BASE + widx);
		end else begin
			load_sel = frame_sel(widx);
		end
	end

	always_ff @(posedge i or negedge rst_n) begin
		if (!rst_n) begin
			state     <= kin_pkg::eng_idle;
			cyc       <= 1'b0;
			busy      <= 1'b0;
			done      <= 1'b0;
			go        <= 1'b0;
			joint     <= 3'd0;
			widx      <= 4'd0;
			type_word <= '0;
		end else begin
			done <= 1'b0;
			go   <= 1'b0;
			if (cyc) begin
				if (ack) begin
					cyc <= 1'b0; // at least one idle cycle between transfers
				end
			end else if (need_bus) begin
				cyc <= 1'b1;
			end
			case (state)
				kin_pkg::eng_idle: begin
					if (start) begin
						busy  <= 1'b1;
						joint <= 3'd0;
						widx  <= 4'd0;
						state <= kin_pkg::eng_fetch_type;
					end
				end
				kin_pkg::eng_fetch_type: begin
					if (xfer) begin
						type_word <= rdata[`JOINTS-1:0];
						state     <= kin_pkg::eng_fetch_zs;
					end
				end
				kin_pkg::eng_fetch_zs: begin
					if (xfer) begin
						if (widx == 4'd5) begin
							widx  <= 4'd0;
							state <= kin_pkg::eng_fetch_frame;
						end else begin
							widx <= widx + 4'd1;
						end
					end
				end
				kin_pkg::eng_fetch_frame: begin
					if (xfer) begin
						if (widx == 4'(`FRAME_WORDS - 1)) begin
							widx  <= 4'd0;
							go    <= 1'b1;
							state <= kin_pkg::eng_compute;
						end else begin
							widx <= widx + 4'd1;
						end
					end
				end
				kin_pkg::eng_compute: begin
					if (ready) begin
						state <= kin_pkg::eng_store_col;
					end
				end
				kin_pkg::eng_store_col: begin
					if (xfer) begin
						if (widx == 4'd5) begin
							widx <= 4'd0;
							if (joint == 3'(`JOINTS - 1)) begin
								state <= kin_pkg::eng_finish;
							end else begin
								joint <= joint + 3'd1;
								state <= kin_pkg::eng_fetch_frame;
							end
						end else begin
							widx <= widx + 4'd1;
						end
					end
				end
				default: begin
					busy  <= 1'b0; // falls with done
					done  <= 1'b1;
					state <= kin_pkg::eng_idle;
				end
			endcase
		end
	end

	column_calc column_calc_inst (
		.i         (i),
		.rst_n     (rst_n),
		.load      (load),
		.load_sel  (load_sel),
		.load_data (load_data),
		.go        (go),
		.revolute  (revolute),
		.res_sel   (res_sel),
		.res_data  (res_data),
		.ready     (ready)
	);

endmodule

//--- source/jacobian_top.sv
// jacobian accelerator top level
// host Wishbone port and engine share the frame store through the arbiter
module jacobian_top (
	input  logic          i,
	input  logic          rst_n,
	input  logic          host_cyc,
	input  logic          host_stb,
	input  logic          host_we,
	input  kin_pkg::adr_t host_adr,
	input  kin_pkg::dat_t host_wdata,
	output kin_pkg::dat_t host_rdata,
	output logic          host_ack,
	input  logic          start,
	output logic          busy,
	output logic          done
);

	logic          eng_cyc;
	logic          eng_stb;
	logic          eng_we;
	kin_pkg::adr_t eng_adr;
	kin_pkg::dat_t eng_wdata;
	kin_pkg::dat_t eng_rdata;
	logic          eng_ack;
	logic          mem_cyc;
	logic          mem_stb;
	logic          mem_we;
	kin_pkg::adr_t mem_adr;
	kin_pkg::dat_t mem_wdata;
	kin_pkg::dat_t mem_rdata;
	logic          mem_ack;

	bus_arbiter bus_arbiter_inst (
		.i          (i),
		.rst_n      (rst_n),
		.host_cyc   (host_cyc),
		.host_stb   (host_stb),
		.host_we    (host_we),
		.host_adr   (host_adr),
		.host_wdata (host_wdata),
		.host_rdata (host_rdata),
		.host_ack   (host_ack),
		.eng_cyc    (eng_cyc),
		.eng_stb    (eng_stb),
		.eng_we     (eng_we),
		.eng_adr    (eng_adr),
		.eng_wdata  (eng_wdata),
		.eng_rdata  (eng_rdata),
		.eng_ack    (eng_ack),
		.mem_cyc    (mem_cyc),
		.mem_stb    (mem_stb),
		.mem_we     (mem_we),
		.mem_adr    (mem_adr),
		.mem_wdata  (mem_wdata),
		.mem_rdata  (mem_rdata),
		.mem_ack    (mem_ack)
	);

	frame_store frame_store_inst (
		.i     (i),
		.rst_n (rst_n),
		.cyc   (mem_cyc),
		.stb   (mem_stb),
		.we    (mem_we),
		.adr   (mem_adr),
		.wdata (mem_wdata),
		.rdata (mem_rdata),
		.ack   (mem_ack)
	);

	jacobian_engine jacobian_engine_inst (
		.i     (i),
		.rst_n (rst_n),
		.start (start),
		.ack   (eng_ack),
		.rdata (eng_rdata),
		.cyc   (eng_cyc),
		.stb   (eng_stb),
		.we    (eng_we),
		.adr   (eng_adr),
		.wdata (eng_wdata),
		.busy  (busy),
		.done  (done)
	);

endmodule

//--- verification/jacobian_tests.svh
// directed jacobian accelerator tests
// included into the testbench module body

task automatic load_frames(input bit identity);
	kin_pkg::fix_t f;
	for (int j = 0; j < `JOINTS; j++) begin
		for (int w = 0; w < `FRAME_WORDS; w++) begin
			if (!identity) begin
				f = rand_fix();
			end else if (w % 4 == 3) begin
				f = kin_pkg::fix_t'((j + 1) * (w + 1) * 'h1000); // small offset
			end else begin
				f = (w % 5 == 0) ? kin_pkg::fix_t'('h10000) : '0; // diagonal 1.0
			end
			host_write(kin_pkg::adr_t'(`FRAME_WORDS * j + w), to_word(f));
		end
	end
endtask

task automatic load_vectors(input bit random_vals);
	kin_pkg::fix_t fixed_zs [6] = '{'h0, 'h0, 'h10000, 'h18000, 'h4000, 'h20000};
	for (int k = 0; k < 6; k++) begin
		host_write(kin_pkg::adr_t'(`Z_BASE + k), to_word(random_vals ? rand_fix() : fixed_zs[k]));
	end
endtask

task automatic check_bus_access();
	kin_pkg::adr_t adrs [4] = '{7'd0, 7'd45, 7'd79, 7'd127};
	kin_pkg::dat_t word;
	@(negedge i);
	check("busy", 32'(busy), 32'd0);
	check("done", 32'(done), 32'd0);
	check("host_ack", 32'(host_ack), 32'd0);
	for (int k = 0; k < 4; k++) begin
		host_write(adrs[k], $random(seed));
	end
	for (int k = 0; k < 4; k++) begin
		host_read(adrs[k], word);
		check($sformatf("mem[%0d]", adrs[k]), word, shadow[adrs[k]]);
	end
endtask

task automatic run_identity_frames();
	load_frames(1'b1);
	load_vectors(1'b0);
	host_write(`TYPE_ADR, 32'h3f); // all revolute
	run_jacobian();
	check_jacobian();
endtask

task automatic run_mixed_joint_types();
	kin_pkg::dat_t word;
	load_frames(1'b0);
	load_vectors(1'b1);
	host_write(`TYPE_ADR, 32'h29); // joints 1, 2, 4 prismatic
	run_jacobian();
	check_jacobian();
	for (int j = 0; j < `JOINTS; j++) begin
		if (!shadow[`TYPE_ADR][j]) begin
			for (int r = 3; r < 6; r++) begin
				host_read(kin_pkg::adr_t'(`JAC_BASE + 6*j + r), word);
				check($sformatf("prismatic jacobian[%0d][%0d]", j, r), word, '0);
			end
		end
	end
endtask

// host traffic competes with the engine for the store
task automatic read_during_run();
	kin_pkg::dat_t word;
	kin_pkg::adr_t adr;
	int base;
	int reads;
	load_frames(1'b0);
	base  = done_count;
	reads = 0;
	pulse_start();
	while (done_count == base) begin
		adr = kin_pkg::adr_t'({$random(seed)} % (`JOINTS * `FRAME_WORDS));
		host_read(adr, word);
		check($sformatf("frame word %0d", adr), word, shadow[adr]);
		@(negedge i);
		if (busy) begin
			reads++; // read finished while the engine ran
		end
	end
	check("reads while busy", 32'(reads > 1), 32'd1);
	check("done count", done_count, base + 1);
	check_jacobian();
endtask

task automatic ignore_second_start();
	int base;
	int run_cycles;
	base = done_count;
	pulse_start();
	repeat (20) @(posedge i);
	@(negedge i);
	check("busy", 32'(busy), 32'd1);
	pulse_start(); // engine already busy
	run_cycles = 22;
	while (done_count == base) begin
		@(posedge i);
		run_cycles++;
	end
	repeat (run_cycles + 20) @(posedge i); // long enough for a queued second run
	check("done count", done_count, base + 1);
	check("busy after run", 32'(busy), 32'd0);
	check_jacobian();
endtask

task automatic rerun_new_vectors();
	load_vectors(1'b1);
	run_jacobian();
	check_jacobian();
endtask

//--- verification/jacobian_tb.sv
// jacobian accelerator testbench
// host Wishbone tasks, Q11.16 reference model, done monitor and watchdog
`include "kin_macros.svh"

module jacobian_tb;

	localparam int PERIOD      = 8;
	localparam int TESTS       = 6;
	localparam int TEST_CYCLES = 3000;

	logic i = 1'b0;
	logic rst_n;
	logic host_cyc;
	logic host_stb;
	logic host_we;
	kin_pkg::adr_t host_adr;
	kin_pkg::dat_t host_wdata;
	kin_pkg::dat_t host_rdata;
	logic host_ack;
	logic start;
	logic busy;
	logic done;

	integer seed = 35;
	int errors = 0;
	int done_count = 0;
	logic busy_q = 1'b0;
	kin_pkg::dat_t shadow [1 << `ADR_W]; // what the host has written
	kin_pkg::fix_t exp_col [6];

	always #(PERIOD / 2) i = ~i;

	jacobian_top jacobian_top_inst (
		.i          (i),
		.rst_n      (rst_n),
		.host_cyc   (host_cyc),
		.host_stb   (host_stb),
		.host_we    (host_we),
		.host_adr   (host_adr),
		.host_wdata (host_wdata),
		.host_rdata (host_rdata),
		.host_ack   (host_ack),
		.start      (start),
		.busy       (busy),
		.done       (done)
	);

	task automatic check(input string name, input kin_pkg::dat_t got, input kin_pkg::dat_t exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			$display("Test failures found");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	// done counted at the falling edge and busy must drop with it
	always @(negedge i) begin
		if (done) begin
			done_count <= done_count + 1;
			check("busy before done", 32'(busy_q), 32'd1);
			check("busy with done", 32'(busy), 32'd0);
		end
		busy_q <= busy;
	end

	initial begin
		#(TESTS * TEST_CYCLES * PERIOD);
		$display("timeout: the DUT did not finish the tests in time");
		$display("Test failures found");
		$fatal(1, "watchdog expired");
	end

	// single classic transfer followed by at least one cycle with cyc low
	task automatic bus_xfer(input logic we, input kin_pkg::adr_t adr, input kin_pkg::dat_t wdata,
		output kin_pkg::dat_t rdata);
		@(posedge i);
		host_cyc   <= 1'b1;
		host_stb   <= 1'b1;
		host_we    <= we;
		host_adr   <= adr;
		host_wdata <= wdata;
		do begin
			@(negedge i);
		end while (!host_ack);
		rdata = host_rdata;
		@(posedge i);
		host_cyc <= 1'b0;
		host_stb <= 1'b0;
		host_we  <= 1'b0;
	endtask

	task automatic host_write(input kin_pkg::adr_t adr, input kin_pkg::dat_t data);
		kin_pkg::dat_t unused;
		shadow[adr] = data;
		bus_xfer(1'b1, adr, data, unused);
	endtask

	task automatic host_read(input kin_pkg::adr_t adr, output kin_pkg::dat_t data);
		bus_xfer(1'b0, adr, '0, data);
	endtask

	task automatic pulse_start();
		@(posedge i);
		start <= 1'b1;
		@(posedge i);
		start <= 1'b0;
	endtask

	function automatic kin_pkg::dat_t to_word(input kin_pkg::fix_t f);
		kin_pkg::dat_t w;
		w = $signed(f); // sign-extended to the bus width
		return w;
	endfunction

	// full product shifted right by the fraction bits and wrapped to 27 bits
	function automatic kin_pkg::fix_t fmul(input kin_pkg::fix_t a, input kin_pkg::fix_t b);
		logic signed [2*`FIX_W-1:0] full;
		full = $signed(a) * $signed(b);
		full = full >>> `FRAC_BITS;
		return full[`FIX_W-1:0];
	endfunction

	function automatic kin_pkg::fix_t rand_fix();
		logic [31:0] r;
		r = $random(seed);
		return kin_pkg::fix_t'($signed(r[19:0])); // about +-8.0
	endfunction

	// expected column j from the words in the shadow store
	task automatic model_column(input int j);
		kin_pkg::fix_t rot [9];
		kin_pkg::fix_t v [3];
		kin_pkg::fix_t p [3];
		for (int r = 0; r < 3; r++) begin
			for (int c = 0; c < 3; c++) begin
				rot[3*r+c] = shadow[`FRAME_WORDS*j + 4*r + c][`FIX_W-1:0];
			end
			p[r] = shadow[`S_BASE + r][`FIX_W-1:0] - shadow[`FRAME_WORDS*j + 4*r + 3][`FIX_W-1:0];
		end
		for (int r = 0; r < 3; r++) begin
			v[r] = '0;
			for (int c = 0; c < 3; c++) begin
				v[r] = v[r] + fmul(rot[3*r+c], shadow[`Z_BASE + c][`FIX_W-1:0]);
			end
		end
		if (shadow[`TYPE_ADR][j]) begin
			exp_col[0] = fmul(v[1], p[2]) - fmul(v[2], p[1]);
			exp_col[1] = fmul(v[2], p[0]) - fmul(v[0], p[2]);
			exp_col[2] = fmul(v[0], p[1]) - fmul(v[1], p[0]);
			for (int k = 0; k < 3; k++) begin
				exp_col[k+3] = v[k];
			end
		end else begin
			for (int k = 0; k < 3; k++) begin
				exp_col[k]   = v[k];
				exp_col[k+3] = '0;
			end
		end
	endtask

	task automatic check_jacobian();
		kin_pkg::dat_t word;
		for (int j = 0; j < `JOINTS; j++) begin
			model_column(j);
			for (int r = 0; r < 6; r++) begin
				host_read(kin_pkg::adr_t'(`JAC_BASE + 6*j + r), word);
				check($sformatf("jacobian[%0d][%0d]", j, r), word, to_word(exp_col[r]));
			end
		end
	endtask

	task automatic run_jacobian();
		int base;
		base = done_count;
		pulse_start();
		while (done_count == base) begin
			@(posedge i);
		end
		repeat (8) @(posedge i);
		check("done count", done_count, base + 1);
	endtask

	`include "jacobian_tests.svh"

	initial begin
		rst_n      = 1'b0;
		host_cyc   = 1'b0;
		host_stb   = 1'b0;
		host_we    = 1'b0;
		host_adr   = '0;
		host_wdata = '0;
		start      = 1'b0;
		repeat (4) @(posedge i);
		rst_n <= 1'b1;
		check_bus_access();
		run_identity_frames();
		run_mixed_joint_types();
		read_during_run();
		ignore_second_start();
		rerun_new_vectors();
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- sim.f
+incdir+source
+incdir+verification
source/kin_pkg.sv
source/frame_store.sv
source/bus_arbiter.sv
source/column_calc.sv
source/jacobian_engine.sv
source/jacobian_top.sv
verification/jacobian_tb.sv
